/* src/core_defs.svh */
// ------------------------------
// Core widths and stack depths
// ------------------------------
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath word
`define CORE_DATA_W 16

// Instruction fields
`define CORE_OPC_W 7
`define CORE_OPR_W 9

// Address spaces
`define CORE_IADDR_W 9
`define CORE_DADDR_W 9
`define CORE_IO_W 3

// Stack depths, power of two so pointers wrap cleanly
`define CORE_RSTACK_DEPTH 8
`define CORE_DSTACK_DEPTH 8

`endif

/* src/isa_pkg.sv */
// ------------------------------
// Instruction set types
// Opcode table and field layout
// ------------------------------
`include "core_defs.svh"

package isa_pkg;

	// Opcode table
	typedef enum logic [`CORE_OPC_W-1:0] {
		op_nop  = 7'd0,  op_lod  = 7'd1,  op_psh  = 7'd2,  op_set  = 7'd3,
		op_setp = 7'd4,  op_add  = 7'd5,  op_and  = 7'd6,  op_orr  = 7'd7,
		op_xor  = 7'd8,  op_les  = 7'd9,  op_equ  = 7'd10, op_inv  = 7'd11,
		op_inn  = 7'd12, op_jmp  = 7'd13, op_jiz  = 7'd14, op_cal  = 7'd15,
		op_ret  = 7'd16, op_out  = 7'd17,
		// Stack forms, operand a comes from the data stack
		op_sadd = 7'd18, op_sand = 7'd19, op_sorr = 7'd20, op_sxor = 7'd21,
		op_sles = 7'd22, op_sequ = 7'd23
	} opcode_t;

	// Address or I/O port field
	typedef logic [`CORE_OPR_W-1:0] operand_t;

	// Full instruction word, opcode in the upper bits
	typedef struct packed {
		opcode_t  opcode;
		operand_t operand;
	} instr_t;

endpackage

/* src/datapath_pkg.sv */
// ------------------------------
// Datapath types
// ALU operations and data word
// ------------------------------
`include "core_defs.svh"

package datapath_pkg;

	// ALU function select
	typedef enum logic [3:0] {
		pass_a, pass_b, add, and_op, or_op, xor_op, les, equ, inv
	} alu_op_t;

	// Signed data word, shared by ALU, accumulator and memory ports
	typedef logic signed [`CORE_DATA_W-1:0] data_t;

endpackage

/* src/lifo_stack.sv */
// ------------------------------
// Parameterised LIFO stack
// ------------------------------
`timescale 1ns/1ps

module lifo_stack #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] top
);

	localparam int PTR_W = $clog2(DEPTH);

	// Storage, no reset needed
	logic [WIDTH-1:0] mem [DEPTH];
	// Points at the next free slot
	logic [PTR_W-1:0] ptr;

	// Pointer wraps silently on overflow or underflow
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Most recent entry sits just below the pointer
	assign top = mem[ptr - 1'b1];

endmodule

/* src/instr_fetch.sv */
// ------------------------------
// Instruction fetch
// Program counter, jump and call
// resolution, return stack
// ------------------------------
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_fetch (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [`CORE_OPC_W+`CORE_OPR_W-1:0]  instr,
	output logic [`CORE_IADDR_W-1:0]            instr_addr,
	input  logic                                acc_bit0,
	output isa_pkg::operand_t                   mem_addr_rd,
	output isa_pkg::opcode_t                    opcode,
	output isa_pkg::operand_t                   operand
);

	import isa_pkg::*;

	instr_t                   fields;
	logic [`CORE_IADDR_W-1:0] pc;
	logic [`CORE_IADDR_W-1:0] pc_inc;
	logic [`CORE_IADDR_W-1:0] pc_next;
	logic [`CORE_IADDR_W-1:0] ret_addr;
	logic                     is_jump;
	logic                     is_cal;
	logic                     is_ret;

	// Field split
	assign fields      = instr_t'(instr);
	assign opcode      = fields.opcode;
	assign operand     = fields.operand;
	// Direct address goes out in the fetch cycle
	assign mem_addr_rd = fields.operand;

	// Flow control decode
	// JIZ looks at bit 0 of the result being executed right now
	assign is_cal  = (fields.opcode == op_cal);
	assign is_ret  = (fields.opcode == op_ret);
	assign is_jump = (fields.opcode == op_jmp) || is_cal ||
		((fields.opcode == op_jiz) && !acc_bit0);

	// Return address is the call's own address plus one
	assign pc_inc = pc + 1'b1;

	always_comb begin
		if (is_jump) begin
			pc_next = fields.operand;
		end else if (is_ret) begin
			pc_next = ret_addr;
		end else begin
			pc_next = pc_inc;
		end
	end

	// Target shows on instr_addr the cycle after the jump is fetched
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	assign instr_addr = pc;

	// ------------------------------
	// Return stack
	// ------------------------------
	lifo_stack #(
		.WIDTH(`CORE_IADDR_W),
		.DEPTH(`CORE_RSTACK_DEPTH)
	) u_rstack (
		.clk (clk),
		.rst (rst),
		.push(is_cal),
		.pop (is_ret),
		.din (pc_inc),
		.top (ret_addr)
	);

endmodule

/* src/instr_decoder.sv */
// ------------------------------
// Opcode decoder
// Fetch-cycle strobes and
// registered execute controls
// ------------------------------
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_decoder (
	input  logic                   clk,
	input  logic                   rst,
	input  isa_pkg::opcode_t       opcode,
	input  isa_pkg::operand_t      operand,
	output datapath_pkg::alu_op_t  alu_op,
	output logic                   sel_stack,
	output logic                   sel_io,
	output logic                   acc_we,
	output logic                   dpush,
	output logic                   dpop,
	output logic                   wr,
	output logic                   out_en_d,
	output logic                   req_in,
	output logic [`CORE_IO_W-1:0]  addr_in,
	output isa_pkg::operand_t      op_q
);

	import isa_pkg::*;
	import datapath_pkg::*;

	alu_op_t alu_d;
	logic    stk_d;
	logic    io_d;
	logic    we_d;
	logic    push_d;
	logic    pop_d;

	// I/O read request leaves in the fetch cycle
	assign req_in  = (opcode == op_inn);
	assign addr_in = operand[`CORE_IO_W-1:0];

	always_comb begin
		// Defaults give NOP, ALU passes the accumulator through
		alu_d    = pass_b;
		stk_d    = 1'b0;
		io_d     = 1'b0;
		we_d     = 1'b0;
		push_d   = 1'b0;
		pop_d    = 1'b0;
		wr       = 1'b0;
		out_en_d = 1'b0;
		case (opcode)
			op_lod: begin
				alu_d = pass_a;
				we_d  = 1'b1;
			end
			// Old acc onto the stack, memory word into acc
			op_psh: begin
				alu_d  = pass_a;
				we_d   = 1'b1;
				push_d = 1'b1;
			end
			op_set:  wr = 1'b1;
			op_setp: begin
				wr    = 1'b1;
				alu_d = pass_a;
				stk_d = 1'b1;
				pop_d = 1'b1;
				we_d  = 1'b1;
			end
			// Memory forms
			op_add: begin alu_d = add;    we_d = 1'b1; end
			op_and: begin alu_d = and_op; we_d = 1'b1; end
			op_orr: begin alu_d = or_op;  we_d = 1'b1; end
			op_xor: begin alu_d = xor_op; we_d = 1'b1; end
			op_les: begin alu_d = les;    we_d = 1'b1; end
			op_equ: begin alu_d = equ;    we_d = 1'b1; end
			op_inv: begin alu_d = inv;    we_d = 1'b1; end
			// Stack forms pop operand a
			op_sadd, op_sand, op_sorr, op_sxor, op_sles, op_sequ: begin
				stk_d = 1'b1;
				pop_d = 1'b1;
				we_d  = 1'b1;
				case (opcode)
					op_sadd: alu_d = add;
					op_sand: alu_d = and_op;
					op_sorr: alu_d = or_op;
					op_sxor: alu_d = xor_op;
					op_sles: alu_d = les;
					default: alu_d = equ;
				endcase
			end
			op_inn: begin
				io_d = 1'b1;
				we_d = 1'b1;
			end
			op_out:  out_en_d = 1'b1;
			// Flow control is handled in fetch
			default: ;
		endcase
	end

	// ------------------------------
	// Execute-stage register
	// ------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op    <= pass_b;
			sel_stack <= 1'b0;
			sel_io    <= 1'b0;
			acc_we    <= 1'b0;
			dpush     <= 1'b0;
			dpop      <= 1'b0;
			op_q      <= '0;
		end else begin
			alu_op    <= alu_d;
			sel_stack <= stk_d;
			sel_io    <= io_d;
			acc_we    <= we_d;
			dpush     <= push_d;
			dpop      <= pop_d;
			op_q      <= operand;
		end
	end

endmodule

/* src/alu.sv */
// ------------------------------
// Integer ALU, combinational
// ------------------------------
`timescale 1ns/1ps

module alu (
	input  datapath_pkg::alu_op_t op,
	input  datapath_pkg::data_t   a,
	input  datapath_pkg::data_t   b,
	output datapath_pkg::data_t   y
);

	import datapath_pkg::*;

	// a is memory word or stack top, b is acc or I/O word
	data_t sum;
	data_t conj;
	data_t disj;
	data_t exor;
	data_t lt;
	data_t eq;
	data_t neg;

	assign sum  = b + a;
	assign conj = b & a;
	assign disj = b | a;
	assign exor = b ^ a;
	// Signed compare, result is 0 or 1
	assign lt   = (b < a) ? data_t'(1) : '0;
	assign eq   = (b == a) ? data_t'(1) : '0;
	// Bitwise inverse of b only
	assign neg  = ~b;

	always_comb begin
		case (op)
			pass_a:  y = a;
			add:     y = sum;
			and_op:  y = conj;
			or_op:   y = disj;
			xor_op:  y = exor;
			les:     y = lt;
			equ:     y = eq;
			inv:     y = neg;
			default: y = b;
		endcase
	end

endmodule

/* src/exec_unit.sv */
// ------------------------------
// Execute stage
// Operand select, data stack,
// accumulator
// ------------------------------
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  datapath_pkg::alu_op_t alu_op,
	input  logic                  sel_stack,
	input  logic                  sel_io,
	input  logic                  acc_we,
	input  logic                  dpush,
	input  logic                  dpop,
	input  datapath_pkg::data_t   mem_data_rd,
	input  datapath_pkg::data_t   io_in,
	output datapath_pkg::data_t   acc,
	output datapath_pkg::data_t   result
);

	import datapath_pkg::*;

	data_t io_q;
	data_t stk_top;
	data_t op_a;
	data_t op_b;

	// I/O word sampled at the edge ending the fetch cycle
	always_ff @(posedge clk) begin
		io_q <= io_in;
	end

	// Operand muxes
	assign op_a = sel_stack ? stk_top : mem_data_rd;
	assign op_b = sel_io ? io_q : acc;

	alu u_alu (
		.op(alu_op),
		.a (op_a),
		.b (op_b),
		.y (result)
	);

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (acc_we) begin
			acc <= result;
		end
	end

	// ------------------------------
	// Data stack
	// ------------------------------
	// Pushes the accumulator before it is overwritten
	lifo_stack #(
		.WIDTH(`CORE_DATA_W),
		.DEPTH(`CORE_DSTACK_DEPTH)
	) u_dstack (
		.clk (clk),
		.rst (rst),
		.push(dpush),
		.pop (dpop),
		.din (acc),
		.top (stk_top)
	);

endmodule

/* src/port_unit.sv */
// ------------------------------
// Memory write and I/O output
// ------------------------------
`timescale 1ns/1ps
`include "core_defs.svh"

module port_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr,
	input  logic                     out_en_d,
	input  isa_pkg::operand_t        op_q,
	input  datapath_pkg::data_t      acc,
	output logic                     mem_wr,
	output logic [`CORE_DADDR_W-1:0] mem_addr_wr,
	output datapath_pkg::data_t      mem_data_wr,
	output logic                     out_en,
	output logic [`CORE_IO_W-1:0]    addr_out
);

	// Strobes move from fetch into execute
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem_wr <= 1'b0;
			out_en <= 1'b0;
		end else begin
			mem_wr <= wr;
			out_en <= out_en_d;
		end
	end

	// Operand is already aligned to the execute cycle
	assign mem_addr_wr = op_q;
	// Port number from the low operand bits
	assign addr_out    = op_q[`CORE_IO_W-1:0];
	// Store and OUT both carry acc before its update
	assign mem_data_wr = acc;

endmodule

/* src/stack_core.sv */
// ------------------------------
// Stack processor core top
// Fetch, decode, execute, ports
// ------------------------------
`timescale 1ns/1ps
`include "core_defs.svh"

module stack_core (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [`CORE_OPC_W+`CORE_OPR_W-1:0] instr,
	output logic [`CORE_IADDR_W-1:0]           instr_addr,
	output logic                               mem_wr,
	output logic [`CORE_DADDR_W-1:0]           mem_addr_rd,
	output logic [`CORE_DADDR_W-1:0]           mem_addr_wr,
	input  datapath_pkg::data_t                mem_data_rd,
	output datapath_pkg::data_t                mem_data_wr,
	input  datapath_pkg::data_t                io_in,
	output logic                               req_in,
	output logic [`CORE_IO_W-1:0]              addr_in,
	output logic                               out_en,
	output logic [`CORE_IO_W-1:0]              addr_out
);

	import isa_pkg::*;
	import datapath_pkg::*;

	opcode_t  opcode;
	operand_t operand;
	operand_t op_q;
	alu_op_t  alu_op;
	logic     sel_stack, sel_io, acc_we;
	logic     dpush, dpop;
	logic     wr, out_en_d;
	data_t    acc;
	data_t    result;

	// ------------------------------
	// Fetch
	// ------------------------------
	instr_fetch u_fetch (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		// JIZ tests the result currently in execute
		.acc_bit0   (result[0]),
		.mem_addr_rd(mem_addr_rd),
		.opcode     (opcode),
		.operand    (operand)
	);

	instr_decoder u_decode (
		.clk      (clk),
		.rst      (rst),
		.opcode   (opcode),
		.operand  (operand),
		.alu_op   (alu_op),
		.sel_stack(sel_stack),
		.sel_io   (sel_io),
		.acc_we   (acc_we),
		.dpush    (dpush),
		.dpop     (dpop),
		.wr       (wr),
		.out_en_d (out_en_d),
		.req_in   (req_in),
		.addr_in  (addr_in),
		.op_q     (op_q)
	);

	// ------------------------------
	// Execute
	// ------------------------------
	exec_unit u_exec (
		.clk        (clk),
		.rst        (rst),
		.alu_op     (alu_op),
		.sel_stack  (sel_stack),
		.sel_io     (sel_io),
		.acc_we     (acc_we),
		.dpush      (dpush),
		.dpop       (dpop),
		.mem_data_rd(mem_data_rd),
		.io_in      (io_in),
		.acc        (acc),
		.result     (result)
	);

	port_unit u_ports (
		.clk        (clk),
		.rst        (rst),
		.wr         (wr),
		.out_en_d   (out_en_d),
		.op_q       (op_q),
		.acc        (acc),
		.mem_wr     (mem_wr),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_wr(mem_data_wr),
		.out_en     (out_en),
		.addr_out   (addr_out)
	);

endmodule

/* tests/tb_stack_core.sv */
// ------------------------------
// Testbench for the stack core
// Clock, memory models, LFSR,
// directed tests and summary
// ------------------------------
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_stack_core;

	import isa_pkg::*;

	localparam int WAIT_LIMIT = 100;
	localparam int RUN_LIMIT  = 5000;
	localparam int MEM_WORDS  = 512;

	logic                                clk;
	logic                                rst;
	logic [`CORE_OPC_W+`CORE_OPR_W-1:0]  instr;
	logic [`CORE_IADDR_W-1:0]            instr_addr;
	logic                                mem_wr;
	logic [`CORE_DADDR_W-1:0]            mem_addr_rd;
	logic [`CORE_DADDR_W-1:0]            mem_addr_wr;
	logic [`CORE_DATA_W-1:0]             mem_data_rd = '0;
	logic [`CORE_DATA_W-1:0]             mem_data_wr;
	logic [`CORE_DATA_W-1:0]             io_in;
	logic                                req_in;
	logic [`CORE_IO_W-1:0]               addr_in;
	logic                                out_en;
	logic [`CORE_IO_W-1:0]               addr_out;

	// Memory images
	logic [15:0] imem [MEM_WORDS];
	logic [15:0] dmem [MEM_WORDS];

	// Observed stores, outputs and input requests
	logic [8:0]  wr_addr_log [$];
	logic [15:0] wr_data_log [$];
	logic [2:0]  out_addr_log [$];
	logic [15:0] out_data_log [$];
	logic [2:0]  in_addr_log [$];
	// Expected stores
	logic [8:0]  exp_addr [$];
	logic [15:0] exp_data [$];

	logic [31:0] lfsr = 32'he866_d4cf;
	string       cur_name;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          total_errs;

	stack_core dut (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		.mem_wr     (mem_wr),
		.mem_addr_rd(mem_addr_rd),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_rd(mem_data_rd),
		.mem_data_wr(mem_data_wr),
		.io_in      (io_in),
		.req_in     (req_in),
		.addr_in    (addr_in),
		.out_en     (out_en),
		.addr_out   (addr_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// Memory and I/O models
	// ------------------------------
	// Instruction memory answers in the same cycle
	assign instr = imem[instr_addr];
	// I/O port k returns 5a00 xor k
	assign io_in = 16'h5a00 ^ {13'd0, addr_in};

	// Synchronous data memory, read sees the old word
	always @(posedge clk) begin
		if (mem_wr) begin
			dmem[mem_addr_wr] <= mem_data_wr;
		end
		mem_data_rd <= dmem[mem_addr_rd];
	end

	// Strobes sampled mid-cycle while stable
	always @(negedge clk) begin
		if (mem_wr) begin
			wr_addr_log.push_back(mem_addr_wr);
			wr_data_log.push_back(mem_data_wr);
		end
		if (out_en) begin
			out_addr_log.push_back(addr_out);
			out_data_log.push_back(mem_data_wr);
		end
		// Fetch of INN while the core runs
		if (req_in && !rst) begin
			in_addr_log.push_back(addr_in);
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] enc(input opcode_t op, input logic [8:0] opr);
		return {op, opr};
	endfunction

	task automatic place_instr(input int addr, input opcode_t op, input logic [8:0] opr);
		imem[addr] = enc(op, opr);
	endtask

	task automatic poke_data(input int addr, input logic [15:0] val);
		dmem[addr] <= val;
	endtask

	task automatic expect_write(input logic [8:0] addr, input logic [15:0] val);
		exp_addr.push_back(addr);
		exp_data.push_back(val);
	endtask

	// Core held in reset while memories are refilled
	task automatic begin_test(input string name);
		int i;
		@(posedge clk);
		#10;
		rst = 1'b1;
		cur_name = name;
		test_errs = 0;
		wr_addr_log.delete();
		wr_data_log.delete();
		out_addr_log.delete();
		out_data_log.delete();
		in_addr_log.delete();
		exp_addr.delete();
		exp_data.delete();
		// Every unused slot jumps to itself
		for (i = 0; i < MEM_WORDS; i++) begin
			imem[i] = enc(op_jmp, i[8:0]);
			dmem[i] <= 16'hd000 ^ {7'd0, i[8:0]};
		end
	endtask

	task automatic release_reset;
		repeat (4) @(posedge clk);
		#10;
		rst = 1'b0;
	endtask

	task automatic wait_writes(input int n);
		int cyc;
		cyc = 0;
		while (wr_addr_log.size() < n && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		if (wr_addr_log.size() < n) begin
			$display("%s: timed out waiting for %0d memory writes, saw %0d",
				cur_name, n, wr_addr_log.size());
			test_errs++;
		end
	endtask

	task automatic wait_outs(input int n);
		int cyc;
		cyc = 0;
		while (out_addr_log.size() < n && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		if (out_addr_log.size() < n) begin
			$display("%s: timed out waiting for %0d OUT strobes, saw %0d",
				cur_name, n, out_addr_log.size());
			test_errs++;
		end
	endtask

	// Observed store sequence against the expected one
	task automatic compare_writes;
		int i;
		int n;
		if (wr_addr_log.size() != exp_addr.size()) begin
			$display("%s: expected %0d memory writes but saw %0d",
				cur_name, exp_addr.size(), wr_addr_log.size());
			test_errs++;
		end
		n = (wr_addr_log.size() < exp_addr.size()) ? wr_addr_log.size() : exp_addr.size();
		for (i = 0; i < n; i++) begin
			if (wr_addr_log[i] != exp_addr[i]) begin
				$display("[ERROR] %s write %0d mem_addr_wr: expected %h, got %h",
					cur_name, i, exp_addr[i], wr_addr_log[i]);
				test_errs++;
			end
			if (wr_data_log[i] != exp_data[i]) begin
				$display("[ERROR] %s write %0d mem_data_wr: expected %h, got %h",
					cur_name, i, exp_data[i], wr_data_log[i]);
				test_errs++;
			end
		end
	endtask

	// Short settle so stray strobes get logged
	task automatic finish_test;
		repeat (8) @(posedge clk);
		compare_writes();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%s: ok", cur_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", cur_name, test_errs);
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic reset_state_test;
		begin_test("reset_state");
		// Loop keeps the strobes busy until reset hits
		place_instr(0, op_lod, 9'h080);
		place_instr(1, op_out, 9'd1);
		place_instr(2, op_set, 9'h081);
		place_instr(3, op_inn, 9'd2);
		place_instr(4, op_jmp, 9'd1);
		release_reset();
		// Reset lands while the store executes and INN is fetched
		repeat (3) @(posedge clk);
		#10;
		rst = 1'b1;
		@(negedge clk);
		if (instr_addr !== 9'd0) begin
			$display("[ERROR] %s instr_addr: expected %h, got %h",
				cur_name, 9'd0, instr_addr);
			test_errs++;
		end
		if (mem_wr !== 1'b0) begin
			$display("[ERROR] %s mem_wr: expected %h, got %h",
				cur_name, 1'b0, mem_wr);
			test_errs++;
		end
		if (out_en !== 1'b0) begin
			$display("[ERROR] %s out_en: expected %h, got %h",
				cur_name, 1'b0, out_en);
			test_errs++;
		end
		if (req_in !== 1'b0) begin
			$display("[ERROR] %s req_in: expected %h, got %h",
				cur_name, 1'b0, req_in);
			test_errs++;
		end
		finish_test();
	endtask

	task automatic mem_alu_test;
		logic [15:0] d [8];
		logic [15:0] acc_m;
		int          i;
		begin_test("mem_alu_forms");
		for (i = 0; i < 8; i++) begin
			d[i] = rand_bits(16);
			poke_data(9'h010 + i, d[i]);
		end
		place_instr(0, op_lod, 9'h010);
		place_instr(1, op_add, 9'h011);
		place_instr(2, op_set, 9'h020);
		place_instr(3, op_and, 9'h012);
		place_instr(4, op_set, 9'h021);
		place_instr(5, op_orr, 9'h013);
		place_instr(6, op_set, 9'h022);
		place_instr(7, op_xor, 9'h014);
		place_instr(8, op_set, 9'h023);
		place_instr(9, op_les, 9'h015);
		place_instr(10, op_set, 9'h024);
		place_instr(11, op_equ, 9'h016);
		place_instr(12, op_set, 9'h025);
		place_instr(13, op_inv, 9'h000);
		place_instr(14, op_set, 9'h026);
		// Equal case always gives one
		place_instr(15, op_lod, 9'h017);
		place_instr(16, op_equ, 9'h017);
		place_instr(17, op_set, 9'h027);
		acc_m = d[0] + d[1];
		expect_write(9'h020, acc_m);
		acc_m = acc_m & d[2];
		expect_write(9'h021, acc_m);
		acc_m = acc_m | d[3];
		expect_write(9'h022, acc_m);
		acc_m = acc_m ^ d[4];
		expect_write(9'h023, acc_m);
		acc_m = ($signed(acc_m) < $signed(d[5])) ? 16'd1 : 16'd0;
		expect_write(9'h024, acc_m);
		acc_m = (acc_m == d[6]) ? 16'd1 : 16'd0;
		expect_write(9'h025, acc_m);
		acc_m = ~acc_m;
		expect_write(9'h026, acc_m);
		expect_write(9'h027, 16'd1);
		release_reset();
		wait_writes(exp_addr.size());
		finish_test();
	endtask

	task automatic stack_forms_test;
		logic [15:0] d [4];
		logic [15:0] sum;
		logic [15:0] lt;
		int          i;
		begin_test("stack_forms");
		for (i = 0; i < 4; i++) begin
			d[i] = rand_bits(16);
			poke_data(9'h030 + i, d[i]);
		end
		// Pops come back newest first
		place_instr(0, op_lod, 9'h030);
		place_instr(1, op_psh, 9'h031);
		place_instr(2, op_psh, 9'h032);
		place_instr(3, op_sadd, 9'h000);
		place_instr(4, op_set, 9'h040);
		place_instr(5, op_psh, 9'h033);
		place_instr(6, op_sles, 9'h000);
		place_instr(7, op_set, 9'h041);
		place_instr(8, op_setp, 9'h042);
		place_instr(9, op_set, 9'h043);
		sum = d[2] + d[1];
		lt  = ($signed(d[3]) < $signed(sum)) ? 16'd1 : 16'd0;
		expect_write(9'h040, sum);
		expect_write(9'h041, lt);
		expect_write(9'h042, lt);
		expect_write(9'h043, d[0]);
		release_reset();
		wait_writes(exp_addr.size());
		finish_test();
	endtask

	task automatic jump_test;
		logic [15:0] odd_w;
		logic [15:0] even_w;
		begin_test("jumps");
		odd_w  = rand_bits(16) | 16'h0001;
		even_w = rand_bits(16) & 16'hfffe;
		poke_data(9'h050, odd_w);
		poke_data(9'h051, even_w);
		place_instr(0, op_lod, 9'h050);
		place_instr(1, op_jmp, 9'd3);
		place_instr(2, op_set, 9'h060);
		place_instr(3, op_set, 9'h061);
		// Odd result before, not taken
		place_instr(4, op_jiz, 9'd6);
		place_instr(5, op_set, 9'h062);
		place_instr(6, op_lod, 9'h051);
		// Even result before, taken
		place_instr(7, op_jiz, 9'd9);
		place_instr(8, op_set, 9'h063);
		place_instr(9, op_set, 9'h064);
		expect_write(9'h061, odd_w);
		expect_write(9'h062, odd_w);
		expect_write(9'h064, even_w);
		release_reset();
		wait_writes(exp_addr.size());
		finish_test();
	endtask

	task automatic call_return_test;
		logic [15:0] v;
		begin_test("call_return");
		v = rand_bits(16);
		poke_data(9'h070, v);
		place_instr(0, op_lod, 9'h070);
		place_instr(1, op_cal, 9'd10);
		place_instr(2, op_set, 9'h071);
		place_instr(3, op_cal, 9'd10);
		place_instr(4, op_set, 9'h072);
		// Routine adds v and writes its marker
		place_instr(10, op_add, 9'h070);
		place_instr(11, op_set, 9'h07f);
		place_instr(12, op_ret, 9'h000);
		expect_write(9'h07f, v + v);
		expect_write(9'h071, v + v);
		expect_write(9'h07f, v + v + v);
		expect_write(9'h072, v + v + v);
		release_reset();
		wait_writes(exp_addr.size());
		finish_test();
	endtask

	task automatic io_test;
		logic [15:0] r;
		logic [2:0]  k [2];
		logic [2:0]  j [2];
		logic [15:0] exp_io;
		int          i;
		begin_test("io");
		for (i = 0; i < 2; i++) begin
			r = rand_bits(3);
			k[i] = r[2:0];
			r = rand_bits(3);
			j[i] = r[2:0];
			place_instr(2 * i, op_inn, {6'd0, k[i]});
			place_instr(2 * i + 1, op_out, {6'd0, j[i]});
		end
		release_reset();
		wait_outs(2);
		if (out_addr_log.size() != 2) begin
			$display("%s: expected 2 OUT strobes but saw %0d", cur_name, out_addr_log.size());
			test_errs++;
		end
		if (in_addr_log.size() != 2) begin
			$display("%s: expected 2 INN requests but saw %0d", cur_name, in_addr_log.size());
			test_errs++;
		end
		for (i = 0; i < 2 && i < in_addr_log.size(); i++) begin
			if (in_addr_log[i] != k[i]) begin
				$display("[ERROR] %s in %0d addr_in: expected %h, got %h",
					cur_name, i, k[i], in_addr_log[i]);
				test_errs++;
			end
		end
		for (i = 0; i < 2 && i < out_addr_log.size(); i++) begin
			exp_io = 16'h5a00 ^ {13'd0, k[i]};
			if (out_addr_log[i] != j[i]) begin
				$display("[ERROR] %s out %0d addr_out: expected %h, got %h",
					cur_name, i, j[i], out_addr_log[i]);
				test_errs++;
			end
			if (out_data_log[i] != exp_io) begin
				$display("[ERROR] %s out %0d mem_data_wr: expected %h, got %h",
					cur_name, i, exp_io, out_data_log[i]);
				test_errs++;
			end
		end
		finish_test();
	endtask

	// ------------------------------
	// Sequence and summary
	// ------------------------------
	initial begin
		rst = 1'b1;
		tests_run = 0;
		tests_failed = 0;
		total_errs = 0;
		reset_state_test();
		mem_alu_test();
		stack_forms_test();
		jump_test();
		call_return_test();
		io_test();
		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, total_errs);
		if (tests_failed != 0) begin
			$display("Test failed");
		end else begin
			$display("Test passed");
		end
		$finish;
	end

	// Whole-run limit
	initial begin
		repeat (RUN_LIMIT) @(posedge clk);
		$display("Simulation ran past its cycle limit and was stopped");
		$display("Test failed");
		$finish;
	end

endmodule

/* sim.f */
+incdir+src
src/isa_pkg.sv
src/datapath_pkg.sv
src/lifo_stack.sv
src/instr_fetch.sv
src/instr_decoder.sv
src/alu.sv
src/exec_unit.sv
src/port_unit.sv
src/stack_core.sv
tests/tb_stack_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_stack_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
